/* hw/writeQueuePkg.sv */
/*
  Shared widths, encodings and the descriptor layout of the DMA write queue.
  The queue is fixed at two slots, so the slot name and the occupancy count
  are sized for that depth only. Reserved encodings are carried through the
  queue unchanged and are never decoded here.
*/
package writeQueuePkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // AXI address width for both descriptor and destination addresses
    localparam int addrWidth = 32;

    // Largest single transfer is 8 MB minus one byte
    localparam int byteCountWidth = 23;

    // One priority level bit
    localparam int priorityWidth = 1;

    // Two slots used alternately
    localparam int queueDepth = 2;

    // Counts 0 to queueDepth inclusive
    localparam int countWidth = 2;

    // Occupancy value at which the queue is full
    localparam logic [countWidth-1:0] fullCount = countWidth'(queueDepth);

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Names one of the two descriptor slots
    typedef enum logic
    {
        slot0 = 1'b0,
        slot1 = 1'b1
    } slotT;

    // Destination address mode
    typedef enum logic [1:0]
    {
        dstIncr  = 2'b00,
        dstFixed = 2'b01,
        dstRsvd2 = 2'b10,
        dstRsvd3 = 2'b11
    } dstOpT;

    // Beat width code, 8 bits shifted left by the code
    typedef enum logic [2:0]
    {
        width8Bit   = 3'd0,
        width16Bit  = 3'd1,
        width32Bit  = 3'd2,
        width64Bit  = 3'd3,
        width128Bit = 3'd4,
        width256Bit = 3'd5,
        width512Bit = 3'd6,
        widthRsvd   = 3'd7
    } dataWidthT;

    ////////////////////////////////////////
    // Write descriptor
    ////////////////////////////////////////

    // One queued write transaction, 99 bits
    typedef struct packed
    {
        // Descriptor write-back rather than a data transfer
        logic                        storeDescriptor;
        // Descriptor was fetched from external memory
        logic                        extDescriptor;
        logic [addrWidth-1:0]        extDescriptorAddr;
        // Data already present when the descriptor was queued
        logic                        dataValid;
        logic [addrWidth-1:0]        dstAddr;
        dstOpT                       dstOp;
        dataWidthT                   dstDataWidth;
        dataWidthT                   srcDataWidth;
        logic [byteCountWidth-1:0]   byteCount;
        logic [priorityWidth-1:0]    priorityLevel;
    } wrDescriptorT;

endpackage

/* hw/descriptorSlots.sv */
/*
  Two write descriptor slots filled alternately, starting at slot0.
  The push pointer does not follow releases, so the consumer must retire
  entries in push order. The producer may only push while the queue
  reports space. Reads are combinational from the slots and the selects.
*/
module descriptorSlots
    import writeQueuePkg::*;
(
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 push,
    input  wrDescriptorT         pushDescriptor,
    input  slotT                 headSel,
    input  slotT                 fetchSel,
    output wrDescriptorT         headDescriptor,
    output logic [addrWidth-1:0] fetchDstAddr
);

    // Descriptor storage
    wrDescriptorT slotReg [queueDepth];

    // Slot that takes the next push
    slotT pushPtr;

    ////////////////////////////////////////
    // Push pointer
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            pushPtr <= slot0;
        end
        else if (push)
        begin
            // Alternate between the two slots
            if (pushPtr == slot0)
            begin
                pushPtr <= slot1;
            end
            else
            begin
                pushPtr <= slot0;
            end
        end
    end

    ////////////////////////////////////////
    // Slot registers
    ////////////////////////////////////////

    // Slots read as zero until first written
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < queueDepth; i++)
            begin
                slotReg[i] <= '0;
            end
        end
        else if (push)
        begin
            slotReg[pushPtr] <= pushDescriptor;
        end
    end

    ////////////////////////////////////////
    // Read selects
    ////////////////////////////////////////

    // Whole head descriptor for the write side
    assign headDescriptor = slotReg[headSel];

    // Read engine only needs where its data goes
    assign fetchDstAddr = slotReg[fetchSel].dstAddr;

endmodule

/* hw/queueTracker.sv */
/*
  Occupancy and data-ready tracking for the two-slot write queue.
  A push adds one entry and each set release bit retires one, on the
  same edge. Pushing into a full queue or releasing more entries than are
  held is illegal and is flagged by the checks below.
  Setting a data-ready flag wins over clearing one in the same cycle.
*/
module queueTracker
    import writeQueuePkg::*;
(
    input  logic       clock,
    input  logic       resetn,
    input  logic       push,
    input  logic       pushStore,
    input  logic [1:0] releaseReq,
    input  slotT       headSel,
    input  slotT       fetchSel,
    input  logic       rdyToAck,
    input  logic       extDataValid,
    output logic       reqInQueue,
    output logic       space
);

    // Entries held
    logic [countWidth-1:0] count;

    // Entries retired this cycle
    logic [countWidth-1:0] releaseCount;

    // Per slot data-ready flags
    logic [queueDepth-1:0] dataReady;

    // Flag set and clear events
    logic dataArrival;
    logic setReady;
    logic clearReady;

    ////////////////////////////////////////
    // Occupancy counter
    ////////////////////////////////////////

    assign releaseCount = countWidth'(releaseReq[0]) + countWidth'(releaseReq[1]);

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            count <= '0;
        end
        else
        begin
            // Push and release on one edge cancel out
            count <= count + countWidth'(push) - releaseCount;
        end
    end

    ////////////////////////////////////////
    // Data-ready flags
    ////////////////////////////////////////

    // External data lands in the slot being fetched
    assign dataArrival = rdyToAck & extDataValid;

    // Store descriptors carry no data so they are ready at once
    assign setReady = dataArrival | (push & pushStore);

    assign clearReady = |releaseReq;

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            dataReady <= '0;
        end
        else if (setReady)
        begin
            dataReady[fetchSel] <= 1'b1;
        end
        else if (clearReady)
        begin
            dataReady[headSel] <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Status outputs
    ////////////////////////////////////////

    assign space = (count < fullCount);

    // Only a head entry with its data ready is offered to the write side
    assign reqInQueue = (count != '0) && dataReady[headSel];

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    noPushWhenFull : assert property (
        @(posedge clock) disable iff (!resetn)
        push |-> (count != fullCount)
    )
    else
    begin
        $error("queueTracker: push while the queue is full");
    end

    // Guards the counter against wrapping over several edges
    countInRange : assert property (
        @(posedge clock) disable iff (!resetn)
        ##1 (count <= fullCount)
    )
    else
    begin
        $error("queueTracker: occupancy above queue depth");
    end

    noOverRelease : assert property (
        @(posedge clock) disable iff (!resetn)
        (releaseReq != 2'b00) |-> (releaseCount <= count)
    )
    else
    begin
        $error("queueTracker: release of more entries than held");
    end

endmodule

/* hw/writeQueue.sv */
/*
  Two-entry write transaction queue of the DMA controller.
  Plain strobes on both sides, with no handshake. The producer pushes only
  while space is high, and the consumer retires entries in push order and
  steers headSel and fetchSel itself.
*/
module writeQueue
    import writeQueuePkg::*;
(
    input  logic                 clock,
    input  logic                 resetn,

    // Producer side
    input  logic                 push,
    input  wrDescriptorT         pushDescriptor,

    // Consumer side
    input  logic [1:0]           releaseReq,
    input  slotT                 headSel,
    input  slotT                 fetchSel,

    // Read engine data arrival
    input  logic                 rdyToAck,
    input  logic                 extDataValid,

    // Queue outputs
    output wrDescriptorT         headDescriptor,
    output logic [addrWidth-1:0] fetchDstAddr,
    output logic                 reqInQueue,
    output logic                 space
);

    ////////////////////////////////////////
    // Descriptor storage
    ////////////////////////////////////////

    descriptorSlots slots
    (
        .clock          (clock),
        .resetn         (resetn),
        .push           (push),
        .pushDescriptor (pushDescriptor),
        .headSel        (headSel),
        .fetchSel       (fetchSel),
        .headDescriptor (headDescriptor),
        .fetchDstAddr   (fetchDstAddr)
    );

    ////////////////////////////////////////
    // Occupancy and readiness
    ////////////////////////////////////////

    // Only the store flag of the pushed descriptor matters to the tracker
    queueTracker tracker
    (
        .clock        (clock),
        .resetn       (resetn),
        .push         (push),
        .pushStore    (pushDescriptor.storeDescriptor),
        .releaseReq   (releaseReq),
        .headSel      (headSel),
        .fetchSel     (fetchSel),
        .rdyToAck     (rdyToAck),
        .extDataValid (extDataValid),
        .reqInQueue   (reqInQueue),
        .space        (space)
    );

endmodule

/* test/writeQueueChecks.sv */
/*
  Reference model and concurrent checks for the two-slot write queue.
  Watches the DUT ports only. The model state is read by the testbench to
  keep its stimulus legal. A failed check prints an error line and raises
  failed, which stays high for the rest of the run.
*/
module writeQueueChecks
    import writeQueuePkg::*;
(
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 push,
    input  wrDescriptorT         pushDescriptor,
    input  logic [1:0]           releaseReq,
    input  slotT                 headSel,
    input  slotT                 fetchSel,
    input  logic                 rdyToAck,
    input  logic                 extDataValid,
    input  wrDescriptorT         headDescriptor,
    input  logic [addrWidth-1:0] fetchDstAddr,
    input  logic                 reqInQueue,
    input  logic                 space,
    output logic                 failed
);
    timeunit 1ns;
    timeprecision 1ps;

    // Model state
    wrDescriptorT modelSlot [2];
    slotT modelPtr;
    int modelCount;
    logic [1:0] modelReady;
    logic pushSeen;

    // Expected outputs
    wrDescriptorT expectedHead;
    logic [addrWidth-1:0] expectedFetchAddr;
    logic expectedSpace;
    logic expectedReq;

    // One sticky flag per check
    logic failReset = 1'b0;
    logic failSpace = 1'b0;
    logic failHead = 1'b0;
    logic failFetch = 1'b0;
    logic failReq = 1'b0;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            modelSlot[0] <= '0;
            modelSlot[1] <= '0;
            modelPtr <= slot0;
            modelCount <= 0;
            modelReady <= 2'b00;
            pushSeen <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                // Slots fill alternately from slot0
                modelSlot[modelPtr] <= pushDescriptor;
                modelPtr <= slotT'(~modelPtr);
                pushSeen <= 1'b1;
            end
            modelCount <= modelCount + int'(push) - int'(releaseReq[0]) - int'(releaseReq[1]);
            // Set wins over clear
            if ((push && pushDescriptor.storeDescriptor) || (rdyToAck && extDataValid))
            begin
                modelReady[fetchSel] <= 1'b1;
            end
            else if (releaseReq != 2'b00)
            begin
                modelReady[headSel] <= 1'b0;
            end
        end
    end

    assign expectedHead = modelSlot[headSel];
    assign expectedFetchAddr = modelSlot[fetchSel].dstAddr;
    assign expectedSpace = (modelCount < 2);
    assign expectedReq = (modelCount != 0) && modelReady[headSel];

    assign failed = failReset | failSpace | failHead | failFetch | failReq;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    resetOutputs : assert property (
        @(posedge clock) disable iff (!resetn)
        !pushSeen |-> (space && !reqInQueue)
    )
    else
    begin
        $display("error: time %0d ns: outputs left reset values before any push", $time);
        failReset = 1'b1;
    end

    spaceMatches : assert property (
        @(posedge clock) disable iff (!resetn)
        space == expectedSpace
    )
    else
    begin
        $display("error: time %0d ns: space %0b with %0d entries held",
            $time, space, modelCount);
        failSpace = 1'b1;
    end

    headMatches : assert property (
        @(posedge clock) disable iff (!resetn)
        headDescriptor == expectedHead
    )
    else
    begin
        $display("error: time %0d ns: headDescriptor %h, expected %h", $time,
            headDescriptor, expectedHead);
        failHead = 1'b1;
    end

    fetchAddrMatches : assert property (
        @(posedge clock) disable iff (!resetn)
        fetchDstAddr == expectedFetchAddr
    )
    else
    begin
        $display("error: time %0d ns: fetchDstAddr %h, expected %h", $time,
            fetchDstAddr, expectedFetchAddr);
        failFetch = 1'b1;
    end

    reqMatches : assert property (
        @(posedge clock) disable iff (!resetn)
        reqInQueue == expectedReq
    )
    else
    begin
        $display("error: time %0d ns: reqInQueue %0b, expected %0b", $time,
            reqInQueue, expectedReq);
        failReq = 1'b1;
    end

endmodule

/* test/writeQueueTb.sv */
/*
  Testbench for the two-slot write queue.
  Random stimulus from a 16-bit LFSR, kept legal against the model count.
  The consumer retires entries in push order and steers headSel and
  fetchSel from the model flags. All checking is in writeQueueChecks.
*/
module writeQueueTb
    import writeQueuePkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int halfPeriod = 50;
    localparam int driveDelay = 10;
    localparam int resetCycles = 3;
    localparam int runCycles = 400;
    localparam int startTimeout = 20;
    localparam int drainTimeout = 8;
    localparam logic [15:0] lfsrSeed = 16'd59;

    logic clock;
    logic resetn;
    logic push;
    wrDescriptorT pushDescriptor;
    logic [1:0] releaseReq;
    slotT headSel;
    slotT fetchSel;
    logic rdyToAck;
    logic extDataValid;
    wrDescriptorT headDescriptor;
    logic [addrWidth-1:0] fetchDstAddr;
    logic reqInQueue;
    logic space;
    logic checkFailed;

    logic [15:0] lfsrState;
    int waited;

    writeQueue dut
    (
        .clock          (clock),
        .resetn         (resetn),
        .push           (push),
        .pushDescriptor (pushDescriptor),
        .releaseReq     (releaseReq),
        .headSel        (headSel),
        .fetchSel       (fetchSel),
        .rdyToAck       (rdyToAck),
        .extDataValid   (extDataValid),
        .headDescriptor (headDescriptor),
        .fetchDstAddr   (fetchDstAddr),
        .reqInQueue     (reqInQueue),
        .space          (space)
    );

    writeQueueChecks checks
    (
        .clock          (clock),
        .resetn         (resetn),
        .push           (push),
        .pushDescriptor (pushDescriptor),
        .releaseReq     (releaseReq),
        .headSel        (headSel),
        .fetchSel       (fetchSel),
        .rdyToAck       (rdyToAck),
        .extDataValid   (extDataValid),
        .headDescriptor (headDescriptor),
        .fetchDstAddr   (fetchDstAddr),
        .reqInQueue     (reqInQueue),
        .space          (space),
        .failed         (checkFailed)
    );

    initial
    begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit taken
    task automatic randomBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[30:0], lfsrState[15]};
            lfsrState = nextLfsr(lfsrState);
        end
    endtask

    task automatic makeDescriptor(output wrDescriptorT d);
        logic [31:0] bits;
        randomBits(32, bits);
        d.dstAddr = bits;
        randomBits(32, bits);
        d.extDescriptorAddr = bits;
        randomBits(23, bits);
        d.byteCount = bits[22:0];
        randomBits(5, bits);
        // Store descriptors about one push in four
        d.storeDescriptor = bits[0] & bits[1];
        d.extDescriptor = bits[2];
        d.dataValid = bits[3];
        d.priorityLevel = bits[4 +: priorityWidth];
        randomBits(8, bits);
        d.dstOp = dstOpT'(bits[1:0]);
        d.dstDataWidth = dataWidthT'(bits[4:2]);
        d.srcDataWidth = dataWidthT'(bits[7:5]);
    endtask

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on failure");
    endtask

    // One cycle of producer, consumer and read engine stimulus
    task automatic driveCycle(input logic allowPush);
        logic [31:0] bits;
        logic [1:0] releaseBits;
        int retired;
        int held;
        slotT other;
        @(posedge clock);
        #driveDelay;
        // Head moves on by the entries retired at this edge
        retired = int'(releaseReq[0]) + int'(releaseReq[1]);
        headSel = slotT'(headSel ^ retired[0]);
        other = slotT'(~headSel);
        held = checks.modelCount;

        randomBits(4, bits);
        releaseBits = {bits[3] & bits[2], bits[1] & bits[0]};
        if (!allowPush)
        begin
            releaseBits = 2'b11;
        end
        if (held == 0)
        begin
            releaseBits = 2'b00;
        end
        else if (held == 1 && releaseBits == 2'b11)
        begin
            releaseBits = 2'b10;
        end
        releaseReq = releaseBits;

        randomBits(2, bits);
        push = allowPush && (held < 2) && (bits[1:0] != 2'b00);
        makeDescriptor(pushDescriptor);

        randomBits(2, bits);
        rdyToAck = bits[0];
        extDataValid = bits[1];

        // Oldest held slot still waiting for data, else the next push slot
        if (held >= 1 && !checks.modelReady[headSel])
        begin
            fetchSel = headSel;
        end
        else if (held == 2 && !checks.modelReady[other])
        begin
            fetchSel = other;
        end
        else
        begin
            fetchSel = (held == 1) ? other : headSel;
        end
    endtask

    always @(posedge checkFailed)
    begin
        stopWithFailure("a checker assertion failed");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        lfsrState = lfsrSeed;
        resetn = 1'b0;
        push = 1'b0;
        pushDescriptor = '0;
        releaseReq = 2'b00;
        headSel = slot0;
        fetchSel = slot0;
        rdyToAck = 1'b0;
        extDataValid = 1'b0;

        repeat (resetCycles) @(posedge clock);
        #driveDelay;
        resetn = 1'b1;

        // Idle checks run until the first push
        waited = 0;
        while (!push)
        begin
            if (waited == startTimeout)
            begin
                stopWithFailure("no push was issued after reset in time");
            end
            else
            begin
                driveCycle(1'b1);
                waited++;
            end
        end

        repeat (runCycles) driveCycle(1'b1);

        // Retire whatever is left
        waited = 0;
        while (checks.modelCount != 0)
        begin
            if (waited == drainTimeout)
            begin
                stopWithFailure("the queue did not drain in time");
            end
            else
            begin
                driveCycle(1'b0);
                waited++;
            end
        end
        driveCycle(1'b0);
        @(posedge clock);
        #1;

        if (checkFailed)
        begin
            stopWithFailure("a check failed during the run");
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* vlog.f */
hw/writeQueuePkg.sv
hw/descriptorSlots.sv
hw/queueTracker.sv
hw/writeQueue.sv
test/writeQueueChecks.sv
test/writeQueueTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the write queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module writeQueueTb -f vlog.f -o writeQueueSim \
    && ./obj_dir/writeQueueSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
